//--- rtl/alu_exec_pkg.sv
package alu_exec_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int XLEN_W       = 64;
  localparam int RNID_W       = 6;   // 64 physical registers.
  localparam int TGT_BUS_SIZE = 2;   // bus 0 is alu writeback, bus 1 is load side.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control encodings.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [3:0] {
    OP_NONE,
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_ADD_32,
    OP_SLL_32,
    OP_SRL_32,
    OP_SRA_32,
    OP_LUI,
    OP_AUIPC
  } op_t;

  // operand 2 replacement taken from the instruction word.
  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_I,      // 12 bit, sign extended.
    IMM_SH,     // 6 bit shamt.
    IMM_SH32    // 5 bit shamt.
  } imm_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pipe payloads.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic              valid;
    logic [31:0]       inst;
    logic [XLEN_W-1:0] pc_addr;
    logic              rs1_valid;
    logic [RNID_W-1:0] rs1_rnid;
    logic              rs2_valid;
    logic [RNID_W-1:0] rs2_rnid;
    logic              rd_valid;
    logic [RNID_W-1:0] rd_rnid;
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rd_rnid;
    logic [XLEN_W-1:0] rd_data;
  } phy_wr_t;

  // wakeup notice, two cycles ahead of the data.
  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rd_rnid;
  } early_wr_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rnid;
  } regread_t;

endpackage

//--- rtl/alu_ctrl_decoder.sv
module alu_ctrl_decoder
  import alu_exec_pkg::*;
(
  input  logic [31:0] i_inst,
  output op_t         o_op,
  output imm_t        o_imm
);

  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP_32    = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic [6:0] w_funct7;
  logic       w_f7_zero;
  logic       w_f7_alt;   // bit 30 set, rest clear.
  logic       w_f6_zero;  // 64 bit shamt leaves inst[25] to the amount.
  logic       w_f6_alt;

  assign w_opcode  = i_inst[6:0];
  assign w_funct3  = i_inst[14:12];
  assign w_funct7  = i_inst[31:25];
  assign w_f7_zero = (w_funct7 == 7'b0000000);
  assign w_f7_alt  = (w_funct7 == 7'b0100000);
  assign w_f6_zero = (i_inst[31:26] == 6'b000000);
  assign w_f6_alt  = (i_inst[31:26] == 6'b010000);

  always_comb begin
    o_op  = OP_NONE;
    o_imm = IMM_NONE;
    case (w_opcode)
      OPC_OP: begin
        case (w_funct3)
          3'b000: o_op = w_f7_zero ? OP_ADD : w_f7_alt ? OP_SUB : OP_NONE;
          3'b001: o_op = w_f7_zero ? OP_SLL : OP_NONE;
          3'b101: o_op = w_f7_zero ? OP_SRL : w_f7_alt ? OP_SRA : OP_NONE;
          default: o_op = OP_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        case (w_funct3)
          3'b000: begin
            o_op  = OP_ADD;
            o_imm = IMM_I;
          end
          3'b001: begin
            o_op  = w_f6_zero ? OP_SLL : OP_NONE;
            o_imm = IMM_SH;
          end
          3'b101: begin
            o_op  = w_f6_zero ? OP_SRL : w_f6_alt ? OP_SRA : OP_NONE;
            o_imm = IMM_SH;
          end
          default: o_op = OP_NONE;
        endcase
      end
      OPC_OP_32: begin
        case (w_funct3)
          3'b000: o_op = w_f7_zero ? OP_ADD_32 : OP_NONE;  // no subw here.
          3'b001: o_op = w_f7_zero ? OP_SLL_32 : OP_NONE;
          3'b101: o_op = w_f7_zero ? OP_SRL_32 : w_f7_alt ? OP_SRA_32 : OP_NONE;
          default: o_op = OP_NONE;
        endcase
      end
      OPC_OP_IMM32: begin
        case (w_funct3)
          3'b000: begin
            o_op  = OP_ADD_32;
            o_imm = IMM_I;
          end
          3'b001: begin
            o_op  = w_f7_zero ? OP_SLL_32 : OP_NONE;
            o_imm = IMM_SH32;
          end
          3'b101: begin
            o_op  = w_f7_zero ? OP_SRL_32 : w_f7_alt ? OP_SRA_32 : OP_NONE;
            o_imm = IMM_SH32;
          end
          default: o_op = OP_NONE;
        endcase
      end
      OPC_LUI:   o_op = OP_LUI;
      OPC_AUIPC: o_op = OP_AUIPC;
      default:   o_op = OP_NONE;
    endcase
  end

endmodule

//--- rtl/phys_regfile.sv
module phys_regfile
  import alu_exec_pkg::*;
#(
  parameter int RF_ENTRIES = 64
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  regread_t          i_rd_req [2],
  input  phy_wr_t           i_wr [TGT_BUS_SIZE],
  output logic [XLEN_W-1:0] o_rd_data [2]
);

  logic [XLEN_W-1:0] r_regs [RF_ENTRIES];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < RF_ENTRIES; e++) begin
        r_regs[e] <= '0;
      end
    end else begin
      for (int b = 0; b < TGT_BUS_SIZE; b++) begin
        if (i_wr[b].valid && (i_wr[b].rd_rnid != '0)) begin
          r_regs[i_wr[b].rd_rnid] <= i_wr[b].rd_data;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < 2; p++) begin : g_rd_port
    logic w_zero;

    assign w_zero = !i_rd_req[p].valid || (i_rd_req[p].rnid == '0);

    always_comb begin
      o_rd_data[p] = r_regs[i_rd_req[p].rnid];
      // same cycle write wins over the array.
      for (int b = 0; b < TGT_BUS_SIZE; b++) begin
        if (i_wr[b].valid && (i_wr[b].rd_rnid == i_rd_req[p].rnid)) begin
          o_rd_data[p] = i_wr[b].rd_data;
        end
      end
      if (w_zero) begin
        o_rd_data[p] = '0;  // x0 and idle port.
      end
    end
  end

endmodule

//--- rtl/onehot_select.sv
module onehot_select #(
  parameter int WIDTH = 64,
  parameter int WORDS = 2
) (
  input  logic [WORDS-1:0] i_oh,
  input  logic [WIDTH-1:0] i_data [WORDS],
  output logic [WIDTH-1:0] o_selected
);

  logic [WIDTH-1:0] w_masked [WORDS];

  for (genvar w = 0; w < WORDS; w++) begin : g_mask
    assign w_masked[w] = i_data[w] & {WIDTH{i_oh[w]}};
  end

  always_comb begin
    o_selected = '0;
    for (int w = 0; w < WORDS; w++) begin
      o_selected = o_selected | w_masked[w];
    end
  end

endmodule

//--- rtl/alu_pipe.sv
module alu_pipe
  import alu_exec_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 16
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  issue_t                   i_issue,
  input  logic [RV_ENTRY_SIZE-1:0] i_issue_index,
  input  phy_wr_t                  i_tgt_wr [TGT_BUS_SIZE],
  input  logic [XLEN_W-1:0]        i_rs1_data,
  input  logic [XLEN_W-1:0]        i_rs2_data,
  output regread_t                 o_rs1_req,
  output regread_t                 o_rs2_req,
  output early_wr_t                o_early_wr,
  output phy_wr_t                  o_phy_wr,
  output logic                     o_done,
  output logic [RV_ENTRY_SIZE-1:0] o_done_index
);

  typedef struct packed {
    op_t  op;
    imm_t imm;
  } pipe_ctrl_t;

  pipe_ctrl_t                 w_ex0_ctrl;

  issue_t                     r_ex1_issue;
  logic [RV_ENTRY_SIZE-1:0]   r_ex1_index;
  pipe_ctrl_t                 r_ex1_ctrl;
  logic [XLEN_W-1:0]          w_ex1_imm;

  issue_t                     r_ex2_issue;
  logic [RV_ENTRY_SIZE-1:0]   r_ex2_index;
  pipe_ctrl_t                 r_ex2_ctrl;
  logic [XLEN_W-1:0]          r_ex2_rs1_data;
  logic [XLEN_W-1:0]          r_ex2_rs2_data;
  logic [TGT_BUS_SIZE-1:0]    w_ex2_rs1_hit;
  logic [TGT_BUS_SIZE-1:0]    w_ex2_rs2_hit;
  logic [XLEN_W-1:0]          w_ex2_tgt_data [TGT_BUS_SIZE];
  logic [XLEN_W-1:0]          w_ex2_rs1_fwd;
  logic [XLEN_W-1:0]          w_ex2_rs2_fwd;
  logic [XLEN_W-1:0]          w_ex2_rs1;
  logic [XLEN_W-1:0]          w_ex2_rs2;
  logic [XLEN_W-1:0]          w_ex2_upper_imm;
  logic [31:0]                w_ex2_word;
  logic [XLEN_W-1:0]          w_ex2_result;

  logic                       r_ex3_valid;
  logic [RV_ENTRY_SIZE-1:0]   r_ex3_index;
  phy_wr_t                    r_ex3_phy_wr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ex0 / ex1.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  alu_ctrl_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_op   (w_ex0_ctrl.op),
    .o_imm  (w_ex0_ctrl.imm)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_index <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_index <= i_issue_index;
      r_ex1_ctrl  <= w_ex0_ctrl;
    end
  end

  assign o_rs1_req.valid = r_ex1_issue.valid & r_ex1_issue.rs1_valid;
  assign o_rs1_req.rnid  = r_ex1_issue.rs1_rnid;
  assign o_rs2_req.valid = r_ex1_issue.valid & r_ex1_issue.rs2_valid;
  assign o_rs2_req.rnid  = r_ex1_issue.rs2_rnid;

  assign o_early_wr.valid   = r_ex1_issue.valid & r_ex1_issue.rd_valid;
  assign o_early_wr.rd_rnid = r_ex1_issue.rd_rnid;

  always_comb begin
    case (r_ex1_ctrl.imm)
      IMM_I:    w_ex1_imm = {{(XLEN_W-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]};
      IMM_SH:   w_ex1_imm = {{(XLEN_W-6){1'b0}}, r_ex1_issue.inst[25:20]};
      IMM_SH32: w_ex1_imm = {{(XLEN_W-5){1'b0}}, r_ex1_issue.inst[24:20]};
      default:  w_ex1_imm = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_issue    <= '0;
      r_ex2_index    <= '0;
      r_ex2_ctrl     <= '0;
      r_ex2_rs1_data <= '0;
      r_ex2_rs2_data <= '0;
    end else begin
      r_ex2_issue    <= r_ex1_issue;
      r_ex2_index    <= r_ex1_index;
      r_ex2_ctrl     <= r_ex1_ctrl;
      r_ex2_rs1_data <= i_rs1_data;
      r_ex2_rs2_data <= (r_ex1_ctrl.imm != IMM_NONE) ? w_ex1_imm : i_rs2_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ex2 forwarding and execute.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar b = 0; b < TGT_BUS_SIZE; b++) begin : g_fwd
    assign w_ex2_rs1_hit[b] = r_ex2_issue.rs1_valid & i_tgt_wr[b].valid &
                              (r_ex2_issue.rs1_rnid == i_tgt_wr[b].rd_rnid) &
                              (r_ex2_issue.rs1_rnid != '0);
    // an immediate in operand 2 is never replaced.
    assign w_ex2_rs2_hit[b] = r_ex2_issue.rs2_valid & i_tgt_wr[b].valid &
                              (r_ex2_ctrl.imm == IMM_NONE) &
                              (r_ex2_issue.rs2_rnid == i_tgt_wr[b].rd_rnid) &
                              (r_ex2_issue.rs2_rnid != '0);
    assign w_ex2_tgt_data[b] = i_tgt_wr[b].rd_data;
  end

  onehot_select #(
    .WIDTH (XLEN_W),
    .WORDS (TGT_BUS_SIZE)
  ) u_rs1_select (
    .i_oh       (w_ex2_rs1_hit),
    .i_data     (w_ex2_tgt_data),
    .o_selected (w_ex2_rs1_fwd)
  );

  onehot_select #(
    .WIDTH (XLEN_W),
    .WORDS (TGT_BUS_SIZE)
  ) u_rs2_select (
    .i_oh       (w_ex2_rs2_hit),
    .i_data     (w_ex2_tgt_data),
    .o_selected (w_ex2_rs2_fwd)
  );

  assign w_ex2_rs1 = |w_ex2_rs1_hit ? w_ex2_rs1_fwd : r_ex2_rs1_data;
  assign w_ex2_rs2 = |w_ex2_rs2_hit ? w_ex2_rs2_fwd : r_ex2_rs2_data;

  assign w_ex2_upper_imm = {{(XLEN_W-32){r_ex2_issue.inst[31]}}, r_ex2_issue.inst[31:12], 12'h000};

  always_comb begin
    case (r_ex2_ctrl.op)
      OP_ADD_32: w_ex2_word = w_ex2_rs1[31:0] + w_ex2_rs2[31:0];
      OP_SLL_32: w_ex2_word = w_ex2_rs1[31:0] << w_ex2_rs2[4:0];
      OP_SRL_32: w_ex2_word = w_ex2_rs1[31:0] >> w_ex2_rs2[4:0];
      OP_SRA_32: w_ex2_word = $signed(w_ex2_rs1[31:0]) >>> w_ex2_rs2[4:0];
      default:   w_ex2_word = '0;
    endcase
  end

  always_comb begin
    case (r_ex2_ctrl.op)
      OP_ADD:   w_ex2_result = w_ex2_rs1 + w_ex2_rs2;
      OP_SUB:   w_ex2_result = w_ex2_rs1 - w_ex2_rs2;
      OP_SLL:   w_ex2_result = w_ex2_rs1 << w_ex2_rs2[5:0];
      OP_SRL:   w_ex2_result = w_ex2_rs1 >> w_ex2_rs2[5:0];
      OP_SRA:   w_ex2_result = $signed(w_ex2_rs1) >>> w_ex2_rs2[5:0];
      OP_ADD_32, OP_SLL_32, OP_SRL_32, OP_SRA_32:
        w_ex2_result = {{(XLEN_W-32){w_ex2_word[31]}}, w_ex2_word};
      OP_LUI:   w_ex2_result = w_ex2_upper_imm;
      OP_AUIPC: w_ex2_result = r_ex2_issue.pc_addr + w_ex2_upper_imm;
      default:  w_ex2_result = '0;  // unsupported still writes back.
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ex3 writeback.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_valid  <= 1'b0;
      r_ex3_index  <= '0;
      r_ex3_phy_wr <= '0;
    end else begin
      r_ex3_valid          <= r_ex2_issue.valid;
      r_ex3_index          <= r_ex2_index;
      r_ex3_phy_wr.valid   <= r_ex2_issue.valid & r_ex2_issue.rd_valid;
      r_ex3_phy_wr.rd_rnid <= r_ex2_issue.rd_rnid;
      r_ex3_phy_wr.rd_data <= w_ex2_result;
    end
  end

  assign o_phy_wr     = r_ex3_phy_wr;
  assign o_done       = r_ex3_valid;
  assign o_done_index = r_ex3_index;

endmodule

//--- rtl/alu_exec_top.sv
module alu_exec_top
  import alu_exec_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 16
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  issue_t                   i_issue,
  input  logic [RV_ENTRY_SIZE-1:0] i_issue_index,
  input  phy_wr_t                  i_ext_wr,
  output early_wr_t                o_early_wr,
  output phy_wr_t                  o_phy_wr,
  output logic                     o_done,
  output logic [RV_ENTRY_SIZE-1:0] o_done_index
);

  localparam int RF_ENTRIES = 1 << RNID_W;

  phy_wr_t           w_alu_wr;
  phy_wr_t           w_tgt_wr [TGT_BUS_SIZE];
  regread_t          w_rs1_req;
  regread_t          w_rs2_req;
  regread_t          w_rd_req [2];
  logic [XLEN_W-1:0] w_rd_data [2];

  assign w_tgt_wr[0] = w_alu_wr;  // own writeback.
  assign w_tgt_wr[1] = i_ext_wr;
  assign w_rd_req[0] = w_rs1_req;
  assign w_rd_req[1] = w_rs2_req;
  assign o_phy_wr    = w_alu_wr;

  alu_pipe #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE)
  ) u_alu_pipe (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue       (i_issue),
    .i_issue_index (i_issue_index),
    .i_tgt_wr      (w_tgt_wr),
    .i_rs1_data    (w_rd_data[0]),
    .i_rs2_data    (w_rd_data[1]),
    .o_rs1_req     (w_rs1_req),
    .o_rs2_req     (w_rs2_req),
    .o_early_wr    (o_early_wr),
    .o_phy_wr      (w_alu_wr),
    .o_done        (o_done),
    .o_done_index  (o_done_index)
  );

  phys_regfile #(
    .RF_ENTRIES (RF_ENTRIES)
  ) u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_req  (w_rd_req),
    .i_wr      (w_tgt_wr),
    .o_rd_data (w_rd_data)
  );

endmodule

//--- test/alu_exec_checker.sv
module alu_exec_checker
  import alu_exec_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 16
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  issue_t                   i_issue,
  input  logic [RV_ENTRY_SIZE-1:0] i_issue_index,
  input  phy_wr_t                  i_ext_wr,
  input  early_wr_t                i_early_wr,
  input  phy_wr_t                  i_phy_wr,
  input  logic                     i_done,
  input  logic [RV_ENTRY_SIZE-1:0] i_done_index,
  output int                       o_error_count,
  output int                       o_check_count
);

  typedef struct packed {
    issue_t                   issue;
    logic [RV_ENTRY_SIZE-1:0] index;
    logic [31:0]              cycle;
    logic [XLEN_W-1:0]        op1;
    logic [XLEN_W-1:0]        op2;
  } pending_t;

  pending_t          pending [$];
  logic [XLEN_W-1:0] model_regs [1 << RNID_W];
  logic [31:0]       cycle_cnt;

  initial begin
    o_error_count = 0;
    o_check_count = 0;
    cycle_cnt     = '0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // expected rv64 result; b_reg is only used by register forms.
  function automatic logic [63:0] ref_result(input logic [31:0] inst, input logic [63:0] pc,
                                             input logic [63:0] a, input logic [63:0] b_reg);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [63:0] imm_i;
    logic [63:0] upper;
    logic [31:0] w;
    opc   = inst[6:0];
    f3    = inst[14:12];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    upper = {{32{inst[31]}}, inst[31:12], 12'h000};
    w     = '0;
    ref_result = '0;
    case (opc)
      7'b0110011: begin
        if (f3 == 3'd0) ref_result = inst[30] ? a - b_reg : a + b_reg;
        if (f3 == 3'd1) ref_result = a << b_reg[5:0];
        if (f3 == 3'd5) begin
          if (inst[30]) ref_result = $signed(a) >>> b_reg[5:0];
          else ref_result = a >> b_reg[5:0];
        end
      end
      7'b0010011: begin
        if (f3 == 3'd0) ref_result = a + imm_i;
        if (f3 == 3'd1) ref_result = a << inst[25:20];
        if (f3 == 3'd5) begin
          if (inst[30]) ref_result = $signed(a) >>> inst[25:20];
          else ref_result = a >> inst[25:20];
        end
      end
      7'b0111011, 7'b0011011: begin
        if (opc == 7'b0011011) b_reg = imm_i;  // shamt sits in imm_i[4:0].
        if (f3 == 3'd0) w = a[31:0] + b_reg[31:0];
        if (f3 == 3'd1) w = a[31:0] << b_reg[4:0];
        if (f3 == 3'd5) begin
          if (inst[30]) w = $signed(a[31:0]) >>> b_reg[4:0];
          else w = a[31:0] >> b_reg[4:0];
        end
        ref_result = {{32{w[31]}}, w};
      end
      7'b0110111: ref_result = upper;
      7'b0010111: ref_result = pc + upper;
      default:    ref_result = '0;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    o_check_count++;
    if (exp !== act) begin
      o_error_count++;
      $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  function automatic logic [63:0] read_model(input logic valid, input logic [RNID_W-1:0] id);
    return (valid && (id != '0)) ? model_regs[id] : 64'd0;  // x0 reads zero.
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per cycle comparison at the falling edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge i_clk) begin : watch
    pending_t          ent;
    pending_t          early_ent;
    logic              expect_done;
    logic              found_early;
    logic [XLEN_W-1:0] exp_data;
    if (!i_reset_n) begin
      compare_value("o_done", 64'd0, 64'(i_done));
      compare_value("o_phy_wr.valid", 64'd0, 64'(i_phy_wr.valid));
      compare_value("o_early_wr.valid", 64'd0, 64'(i_early_wr.valid));
      pending.delete();
      for (int r = 0; r < (1 << RNID_W); r++) begin
        model_regs[r] = '0;
      end
      cycle_cnt = '0;
    end else begin
      cycle_cnt = cycle_cnt + 32'd1;
      expect_done = (pending.size() > 0) && (pending[0].cycle == cycle_cnt - 32'd3);
      if (expect_done) begin
        ent      = pending.pop_front();
        exp_data = ref_result(ent.issue.inst, ent.issue.pc_addr, ent.op1, ent.op2);
        if (!i_done) begin
          o_error_count++;
          $display("missing done at time %0t for instruction issued in cycle %0d",
                   $time, ent.cycle);
        end else begin
          compare_value("o_done_index", 64'(ent.index), 64'(i_done_index));
        end
        compare_value("o_phy_wr.valid", 64'(ent.issue.rd_valid), 64'(i_phy_wr.valid));
        if (ent.issue.rd_valid) begin
          compare_value("o_phy_wr.rd_rnid", 64'(ent.issue.rd_rnid), 64'(i_phy_wr.rd_rnid));
          compare_value("o_phy_wr.rd_data", exp_data, i_phy_wr.rd_data);
          if (ent.issue.rd_rnid != '0) model_regs[ent.issue.rd_rnid] = exp_data;
        end
      end else begin
        if (i_done) begin
          o_error_count++;
          $display("unexpected done at time %0t with no instruction due", $time);
        end
        compare_value("o_phy_wr.valid", 64'd0, 64'(i_phy_wr.valid));
      end
      if (i_ext_wr.valid && (i_ext_wr.rd_rnid != '0)) begin
        model_regs[i_ext_wr.rd_rnid] = i_ext_wr.rd_data;
      end
      // operands are taken once every write up to issue+2 is in.
      found_early = 1'b0;
      early_ent   = '0;
      for (int i = 0; i < pending.size(); i++) begin
        if (pending[i].cycle == cycle_cnt - 32'd2) begin
          pending[i].op1 = read_model(pending[i].issue.rs1_valid, pending[i].issue.rs1_rnid);
          pending[i].op2 = read_model(pending[i].issue.rs2_valid, pending[i].issue.rs2_rnid);
        end
        if (pending[i].cycle == cycle_cnt - 32'd1) begin
          found_early = 1'b1;
          early_ent   = pending[i];
        end
      end
      compare_value("o_early_wr.valid", 64'(found_early & early_ent.issue.rd_valid),
                    64'(i_early_wr.valid));
      if (found_early && early_ent.issue.rd_valid) begin
        compare_value("o_early_wr.rd_rnid", 64'(early_ent.issue.rd_rnid),
                      64'(i_early_wr.rd_rnid));
      end
      if (i_issue.valid) begin
        ent       = '0;
        ent.issue = i_issue;
        ent.index = i_issue_index;
        ent.cycle = cycle_cnt;
        pending.push_back(ent);
      end
    end
  end

endmodule

//--- test/tb_alu_exec.sv
module tb_alu_exec
  import alu_exec_pkg::*;
();

  localparam int RV_ENTRY_SIZE = 16;
  localparam int NUM_INSTS     = 400;
  localparam int DONE_TIMEOUT  = 200;

  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_32    = 7'b0111011;
  localparam logic [6:0] OPC_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;

  logic                     clk;
  logic                     reset_n;
  issue_t                   issue;
  logic [RV_ENTRY_SIZE-1:0] issue_index;
  phy_wr_t                  ext_wr;
  early_wr_t                early_wr;
  phy_wr_t                  phy_wr;
  logic                     done;
  logic [RV_ENTRY_SIZE-1:0] done_index;
  int                       error_count;
  int                       check_count;

  logic [31:0]       seed;
  logic [RNID_W-1:0] last_rd;
  logic [RNID_W:0]   wb_hist [3];  // {valid, rnid} of the last three issues.
  int                issued     = 0;
  int                dones_seen = 0;
  logic              timed_out;
  int                wait_cycles;

  always #10 clk = ~clk;

  alu_exec_top #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE)
  ) u_dut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_issue       (issue),
    .i_issue_index (issue_index),
    .i_ext_wr      (ext_wr),
    .o_early_wr    (early_wr),
    .o_phy_wr      (phy_wr),
    .o_done        (done),
    .o_done_index  (done_index)
  );

  alu_exec_checker #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE)
  ) u_check (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_issue       (issue),
    .i_issue_index (issue_index),
    .i_ext_wr      (ext_wr),
    .i_early_wr    (early_wr),
    .i_phy_wr      (phy_wr),
    .i_done        (done),
    .i_done_index  (done_index),
    .o_error_count (error_count),
    .o_check_count (check_count)
  );

  always @(negedge clk) begin
    if (reset_n && done) dones_seen++;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift32(seed);
    return seed;
  endfunction

  function automatic issue_t random_issue();
    issue_t      it;
    logic [31:0] r;
    logic [31:0] x;
    logic [31:0] lo;
    int          kind;
    r    = next_rand();
    x    = next_rand();
    kind = int'(r % 32'd19);
    it   = '0;
    it.valid = 1'b1;
    case (kind)
      0:  it.inst = {7'h00, r[14:10], r[9:5], 3'd0, r[19:15], OPC_OP};  // add.
      1:  it.inst = {7'h20, r[14:10], r[9:5], 3'd0, r[19:15], OPC_OP};
      2:  it.inst = {7'h00, r[14:10], r[9:5], 3'd1, r[19:15], OPC_OP};
      3:  it.inst = {7'h00, r[14:10], r[9:5], 3'd5, r[19:15], OPC_OP};
      4:  it.inst = {7'h20, r[14:10], r[9:5], 3'd5, r[19:15], OPC_OP};  // sra.
      5:  it.inst = {x[11:0], r[9:5], 3'd0, r[19:15], OPC_IMM};
      6:  it.inst = {6'h00, x[5:0], r[9:5], 3'd1, r[19:15], OPC_IMM};
      7:  it.inst = {6'h00, x[5:0], r[9:5], 3'd5, r[19:15], OPC_IMM};
      8:  it.inst = {6'h10, x[5:0], r[9:5], 3'd5, r[19:15], OPC_IMM};   // srai.
      9:  it.inst = {7'h00, r[14:10], r[9:5], 3'd0, r[19:15], OPC_32};
      10: it.inst = {7'h00, r[14:10], r[9:5], 3'd1, r[19:15], OPC_32};
      11: it.inst = {7'h00, r[14:10], r[9:5], 3'd5, r[19:15], OPC_32};
      12: it.inst = {7'h20, r[14:10], r[9:5], 3'd5, r[19:15], OPC_32};
      13: it.inst = {x[11:0], r[9:5], 3'd0, r[19:15], OPC_IMM32};
      14: it.inst = {7'h00, x[4:0], r[9:5], 3'd1, r[19:15], OPC_IMM32};
      15: it.inst = {7'h00, x[4:0], r[9:5], 3'd5, r[19:15], OPC_IMM32};
      16: it.inst = {7'h20, x[4:0], r[9:5], 3'd5, r[19:15], OPC_IMM32};
      17: it.inst = {x[19:0], r[19:15], OPC_LUI};
      default: it.inst = {x[19:0], r[19:15], OPC_AUIPC};
    endcase
    lo = next_rand();
    it.pc_addr   = {next_rand(), lo[31:2], 2'b00};
    it.rs1_valid = (kind <= 16);
    it.rs2_valid = (kind <= 4) || ((kind >= 9) && (kind <= 12));
    r = next_rand();
    // a quarter of the sources depend on the previous destination.
    it.rs1_rnid = (r[1:0] == 2'b00) ? last_rd : {2'b00, r[7:4]};
    it.rs2_rnid = (r[3:2] == 2'b00) ? last_rd : {2'b00, r[11:8]};
    it.rd_valid = (r[14:12] != 3'b000);
    it.rd_rnid  = {2'b00, r[19:16]};
    last_rd     = it.rd_rnid;
    return it;
  endfunction

  task automatic drive_random_cycle(input logic allow_issue);
    issue_t                   next_issue;
    logic [RV_ENTRY_SIZE-1:0] next_index;
    phy_wr_t                  next_ext;
    logic [31:0]              r;
    @(posedge clk);
    next_issue = '0;
    next_index = '0;
    next_ext   = '0;
    r = next_rand();
    if (allow_issue && (r[1:0] != 2'b00)) begin
      next_issue = random_issue();
      next_index[r[7:4]] = 1'b1;
      issued++;
    end
    if (r[8]) begin
      next_ext.valid   = 1'b1;
      next_ext.rd_rnid = {2'b00, r[15:12]};
      // bus 0 carries the issue of three cycles back.
      if (wb_hist[2][RNID_W] && (next_ext.rd_rnid == wb_hist[2][RNID_W-1:0])) begin
        next_ext.rd_rnid = wb_hist[2][RNID_W-1:0] + 6'd1;
      end
      next_ext.rd_data = {next_rand(), next_rand()};
    end
    wb_hist[2] = wb_hist[1];
    wb_hist[1] = wb_hist[0];
    wb_hist[0] = {next_issue.valid & next_issue.rd_valid, next_issue.rd_rnid};
    issue       <= next_issue;
    issue_index <= next_index;
    ext_wr      <= next_ext;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    issue       = '0;
    issue_index = '0;
    ext_wr      = '0;
    seed        = 32'd99554;
    last_rd     = '0;
    timed_out   = 1'b0;
    for (int h = 0; h < 3; h++) begin
      wb_hist[h] = '0;
    end
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    while (issued < NUM_INSTS) begin
      drive_random_cycle(1'b1);
    end
    wait_cycles = 0;
    while ((dones_seen < issued) && (wait_cycles < DONE_TIMEOUT)) begin
      drive_random_cycle(1'b0);
      wait_cycles++;
    end
    if (dones_seen < issued) begin
      timed_out = 1'b1;
      $display("timeout while waiting for done: %0d of %0d instructions completed",
               dones_seen, issued);
    end
    repeat (4) drive_random_cycle(1'b0);  // catch stray dones.
    $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timed_out ? 1 : 0);
    if (timed_out || (error_count != 0)) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule

//--- verilog.f
rtl/alu_exec_pkg.sv
rtl/alu_ctrl_decoder.sv
rtl/phys_regfile.sv
rtl/onehot_select.sv
rtl/alu_pipe.sv
rtl/alu_exec_top.sv
test/alu_exec_checker.sv
test/tb_alu_exec.sv

//--- run.sh
#!/bin/sh
# build the alu execution pipe testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_alu_exec

verilator --binary -j 0 --top-module tb_alu_exec -Mdir obj_dir -o "$BIN" -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
  echo "simulation log holds no result line"
  exit 1
fi
exit 0
